/* hockey_pkg.sv */
`default_nettype none

package hockey_pkg;

    // game phases, one per FSM state
    typedef enum logic [3:0] {
        ST_IDLE,      // waiting for first server pick
        ST_INTRO,     // "0 0" shown before first serve
        ST_SERVE_A,
        ST_SERVE_B,
        ST_TO_B,      // puck travelling A -> B
        ST_TO_A,      // puck travelling B -> A
        ST_RESP_B,    // B must hit
        ST_RESP_A,    // A must hit
        ST_GOAL,
        ST_OVER
    } game_state_e;

    // row motion of the puck
    typedef enum logic [1:0] {
        DIR_STRAIGHT = 2'd0,
        DIR_UP       = 2'd1,
        DIR_DOWN     = 2'd2,
        DIR_RSVD     = 2'd3   // behaves as straight
    } dir_e;

    typedef logic [1:0] score_t;

    // court limits
    localparam logic [2:0] X_MAX = 3'd4;   // last column, B side
    localparam logic [2:0] Y_MAX = 3'd4;   // top row

    localparam score_t WIN_SCORE = 2'd3;

    // phase lengths in clock cycles
    localparam logic [2:0] INTRO_CYCLES = 3'd3;
    localparam logic [2:0] RESP_CYCLES  = 3'd3;
    localparam logic [2:0] GOAL_CYCLES  = 3'd4;

    // seven-segment patterns, active low, abcdefg with g in bit 0
    localparam logic [6:0] SSD_DIGIT [4] = '{
        7'b0000001,   // 0
        7'b1001111,   // 1
        7'b0010010,   // 2
        7'b0000110    // 3
    };

    localparam logic [6:0] SSD_BLANK = 7'b1111111;
    localparam logic [6:0] SSD_DASH  = 7'b1111110;  // g only

    localparam logic [4:0] LED_GAMEOVER = 5'b10101;

endpackage

`default_nettype wire

/* puck_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface puck_if
    import hockey_pkg::*;
();

    // commands from the game FSM
    logic       load;        // place puck, wins over step
    logic       step;        // advance one column
    logic       toward_b;    // heading of a load
    logic [2:0] y_start;
    dir_e       dir_start;

    // current puck position
    logic [2:0] x;
    logic [2:0] y;

    modport ctrl    (output load, step, toward_b, y_start, dir_start, input x, y);
    modport tracker (input load, step, toward_b, y_start, dir_start, output x, y);
    modport view    (input x);

endinterface

`default_nettype wire

/* puck_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module puck_tracker
    import hockey_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    puck_if.tracker puck
);

    logic [2:0] col_q;
    logic [2:0] row_q;
    dir_e       dir_q;
    logic       heading_b_q;   // 1 while moving toward B

    logic [2:0] row_d;
    dir_e       dir_d;

    // row bounce: hold at the wall and flip direction
    always_comb begin
        row_d = row_q;
        dir_d = dir_q;
        case (dir_q)
            DIR_UP: begin
                if (row_q >= Y_MAX) begin
                    dir_d = DIR_DOWN;
                end else begin
                    row_d = row_q + 3'd1;
                end
            end
            DIR_DOWN: begin
                if (row_q == 3'd0) begin
                    dir_d = DIR_UP;
                end else begin
                    row_d = row_q - 3'd1;
                end
            end
            default: ;   // straight and reserved keep the row
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            col_q       <= 3'd0;
            row_q       <= 3'd0;
            dir_q       <= DIR_STRAIGHT;
            heading_b_q <= 1'b0;
        end else if (puck.load) begin
            col_q       <= puck.toward_b ? 3'd0 : X_MAX;
            row_q       <= puck.y_start;
            dir_q       <= puck.dir_start;
            heading_b_q <= puck.toward_b;
        end else if (puck.step) begin
            if (heading_b_q) begin
                col_q <= col_q + 3'd1;
            end else begin
                col_q <= col_q - 3'd1;
            end
            row_q <= row_d;
            dir_q <= dir_d;
        end
    end

    assign puck.x = col_q;
    assign puck.y = row_q;

endmodule

`default_nettype wire

/* rally_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module rally_fsm
    import hockey_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        btn_a,
    input  logic        btn_b,
    input  dir_e        dir_a,
    input  dir_e        dir_b,
    input  logic [2:0]  y_a,
    input  logic [2:0]  y_b,
    puck_if.ctrl        puck,
    output game_state_e state,
    output score_t      score_a,
    output score_t      score_b
);

    game_state_e state_q;
    game_state_e state_d;
    logic [2:0]  timer_q;      // shared by intro, response and goal
    score_t      score_a_q;
    score_t      score_b_q;
    logic        serve_a_q;    // next server is A
    logic        scorer_a_q;   // last point went to A

    logic serve_ok_a;
    logic serve_ok_b;
    logic resp_last;
    logic timed;
    logic return_a;            // A hits back
    logic return_b;
    logic point_a;             // A scores this cycle
    logic point_b;
    logic a_side;

    assign serve_ok_a = btn_a && (y_a <= Y_MAX);
    assign serve_ok_b = btn_b && (y_b <= Y_MAX);
    assign resp_last  = (timer_q == RESP_CYCLES - 3'd1);
    assign timed      = state_q inside {ST_INTRO, ST_RESP_B, ST_RESP_A, ST_GOAL};

    // first press in the window decides, no press until the end is a miss
    assign return_b = (state_q == ST_RESP_B) && btn_b && (y_b == puck.y);
    assign return_a = (state_q == ST_RESP_A) && btn_a && (y_a == puck.y);
    assign point_a  = (state_q == ST_RESP_B) && (btn_b ? (y_b != puck.y) : resp_last);
    assign point_b  = (state_q == ST_RESP_A) && (btn_a ? (y_a != puck.y) : resp_last);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (btn_a != btn_b) begin
                    state_d = ST_INTRO;
                end
            end
            ST_INTRO: begin
                if (timer_q == INTRO_CYCLES - 3'd1) begin
                    state_d = serve_a_q ? ST_SERVE_A : ST_SERVE_B;
                end
            end
            ST_SERVE_A: if (serve_ok_a) state_d = ST_TO_B;
            ST_SERVE_B: if (serve_ok_b) state_d = ST_TO_A;
            ST_TO_B: begin
                if (puck.x == X_MAX - 3'd1) begin   // arrives on this edge
                    state_d = ST_RESP_B;
                end
            end
            ST_TO_A: begin
                if (puck.x == 3'd1) begin
                    state_d = ST_RESP_A;
                end
            end
            ST_RESP_B: begin
                if (return_b) begin
                    state_d = ST_TO_A;
                end else if (point_a) begin
                    state_d = ST_GOAL;
                end
            end
            ST_RESP_A: begin
                if (return_a) begin
                    state_d = ST_TO_B;
                end else if (point_b) begin
                    state_d = ST_GOAL;
                end
            end
            ST_GOAL: begin
                if (timer_q == GOAL_CYCLES - 3'd1) begin
                    if ((scorer_a_q ? score_a_q : score_b_q) == WIN_SCORE) begin
                        state_d = ST_OVER;
                    end else begin
                        state_d = serve_a_q ? ST_SERVE_A : ST_SERVE_B;
                    end
                end
            end
            ST_OVER: ;   // held until reset
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            timer_q    <= 3'd0;
            score_a_q  <= '0;
            score_b_q  <= '0;
            serve_a_q  <= 1'b1;
            scorer_a_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (!timed || (state_d != state_q)) begin
                timer_q <= 3'd0;   // restart on every phase change
            end else begin
                timer_q <= timer_q + 3'd1;
            end
            if ((state_q == ST_IDLE) && (btn_a != btn_b)) begin
                serve_a_q <= btn_a;
            end
            if (point_a) begin
                score_a_q  <= score_a_q + 2'd1;
                scorer_a_q <= 1'b1;
                serve_a_q  <= 1'b0;   // B conceded, B serves
            end
            if (point_b) begin
                score_b_q  <= score_b_q + 2'd1;
                scorer_a_q <= 1'b0;
                serve_a_q  <= 1'b1;
            end
        end
    end

    // puck commands straight from state and inputs
    assign a_side         = state_q inside {ST_SERVE_A, ST_RESP_A};
    assign puck.load      = ((state_q == ST_SERVE_A) && serve_ok_a)
                          || ((state_q == ST_SERVE_B) && serve_ok_b)
                          || return_a || return_b;
    assign puck.step      = state_q inside {ST_TO_B, ST_TO_A};
    assign puck.toward_b  = a_side;
    assign puck.y_start   = a_side ? y_a : y_b;     // equals puck row on a hit
    assign puck.dir_start = a_side ? dir_a : dir_b;

    assign state   = state_q;
    assign score_a = score_a_q;
    assign score_b = score_b_q;

endmodule

`default_nettype wire

/* court_display.sv */
`timescale 1ns/1ps
`default_nettype none

module court_display
    import hockey_pkg::*;
(
    input  game_state_e state,
    input  score_t      score_a,
    input  score_t      score_b,
    puck_if.view        puck,
    output logic        led_a,
    output logic        led_b,
    output logic [4:0]  led_x,
    output logic [6:0]  ssd7,
    output logic [6:0]  ssd6,
    output logic [6:0]  ssd5,
    output logic [6:0]  ssd4,
    output logic [6:0]  ssd3,
    output logic [6:0]  ssd2,
    output logic [6:0]  ssd1,
    output logic [6:0]  ssd0
);

    logic [X_MAX:0] puck_onehot;
    logic           show_score;
    logic [6:0]     filler;       // pattern for the six unused digits

    assign puck_onehot = {{X_MAX{1'b0}}, 1'b1} << puck.x;

    always_comb begin
        led_a = 1'b0;
        led_b = 1'b0;
        led_x = '0;
        case (state)
            ST_IDLE: begin
                led_a = 1'b1;
                led_b = 1'b1;
            end
            ST_SERVE_A: led_a = 1'b1;
            ST_SERVE_B: led_b = 1'b1;
            ST_TO_B, ST_TO_A: begin
                led_x = puck_onehot;
            end
            ST_RESP_A: begin
                led_a = 1'b1;
                led_x = puck_onehot;   // puck waiting at column 0
            end
            ST_RESP_B: begin
                led_b = 1'b1;
                led_x = puck_onehot;
            end
            ST_INTRO, ST_GOAL: begin
                led_x = '1;
            end
            ST_OVER: led_x = LED_GAMEOVER;
            default: ;
        endcase
    end

    // scores only on intro, goal and game over screens
    assign show_score = state inside {ST_INTRO, ST_GOAL, ST_OVER};
    assign filler     = show_score ? SSD_DASH : SSD_BLANK;

    assign ssd7 = filler;
    assign ssd6 = filler;
    assign ssd5 = filler;
    assign ssd4 = show_score ? SSD_DIGIT[score_a] : SSD_BLANK;   // player A
    assign ssd3 = filler;
    assign ssd2 = filler;
    assign ssd1 = filler;
    assign ssd0 = show_score ? SSD_DIGIT[score_b] : SSD_BLANK;   // player B

endmodule

`default_nettype wire

/* hockey_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hockey_top
    import hockey_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       btn_a,
    input  logic       btn_b,
    input  logic [1:0] dir_a,
    input  logic [1:0] dir_b,
    input  logic [2:0] y_a,
    input  logic [2:0] y_b,
    output logic       led_a,
    output logic       led_b,
    output logic [4:0] led_x,
    output logic [6:0] ssd7,
    output logic [6:0] ssd6,
    output logic [6:0] ssd5,
    output logic [6:0] ssd4,
    output logic [6:0] ssd3,
    output logic [6:0] ssd2,
    output logic [6:0] ssd1,
    output logic [6:0] ssd0
);

    game_state_e state;
    score_t      score_a;
    score_t      score_b;

    puck_if puck_bus ();

    puck_tracker u_tracker (
        .clk  (clk),
        .rst  (rst),
        .puck (puck_bus.tracker)
    );

    rally_fsm u_fsm (
        .clk     (clk),
        .rst     (rst),
        .btn_a   (btn_a),
        .btn_b   (btn_b),
        .dir_a   (dir_e'(dir_a)),
        .dir_b   (dir_e'(dir_b)),
        .y_a     (y_a),
        .y_b     (y_b),
        .puck    (puck_bus.ctrl),
        .state   (state),
        .score_a (score_a),
        .score_b (score_b)
    );

    court_display u_display (
        .state   (state),
        .score_a (score_a),
        .score_b (score_b),
        .puck    (puck_bus.view),
        .led_a   (led_a),
        .led_b   (led_b),
        .led_x   (led_x),
        .ssd7    (ssd7),
        .ssd6    (ssd6),
        .ssd5    (ssd5),
        .ssd4    (ssd4),
        .ssd3    (ssd3),
        .ssd2    (ssd2),
        .ssd1    (ssd1),
        .ssd0    (ssd0)
    );

endmodule

`default_nettype wire

/* tb_hockey_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hockey_assert
    import hockey_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       led_a,
    input wire logic       led_b,
    input wire logic [4:0] led_x,
    input wire logic [6:0] ssd4,
    input wire logic [6:0] ssd0
);

    logic travel;   // puck in flight, no player LED lit
    logic over;

    assign travel = !led_a && !led_b && (led_x != 5'h00) && (led_x != 5'h1f)
                    && (led_x != LED_GAMEOVER);
    assign over   = (led_x == LED_GAMEOVER);

    // idle pattern whenever reset is held
    reset_leds: assert property (@(posedge clk) rst |-> (led_a && led_b && (led_x == 5'h00)))
        else $error("LEDs not in reset pattern while rst is high");

    travel_onehot: assert property (@(posedge clk) disable iff (rst) travel |-> $onehot(led_x))
        else $error("puck column LEDs not one-hot during travel");

    // one column per clock, either way
    travel_step: assert property (@(posedge clk) disable iff (rst)
        (travel && $past(travel)) |->
        ((led_x == ($past(led_x) << 1)) || (led_x == ($past(led_x) >> 1))))
        else $error("puck did not move by one column");

    over_hold: assert property (@(posedge clk) disable iff (rst)
        $past(over) |-> (over && $stable(ssd4) && $stable(ssd0)))
        else $error("game over screen or final scores changed before reset");

endmodule

`default_nettype wire

/* tb_hockey.sv */
`timescale 1ns/1ps
`default_nettype none

bind hockey_top tb_hockey_assert i_assert (.*);

module tb_hockey
    import hockey_pkg::*;
();

    localparam int RALLY_CYCLES = int'(INTRO_CYCLES) + 20 + int'(GOAL_CYCLES)
                                  + 4 * (int'(X_MAX) + int'(RESP_CYCLES) + 2);
    localparam int TIMEOUT_NS   = (5 * RALLY_CYCLES + 60) * 20;

    logic       clk;
    logic       rst;
    logic       btn_a;
    logic       btn_b;
    logic [1:0] dir_a;
    logic [1:0] dir_b;
    logic [2:0] y_a;
    logic [2:0] y_b;
    logic       led_a;
    logic       led_b;
    logic [4:0] led_x;
    logic [6:0] ssd7;
    logic [6:0] ssd6;
    logic [6:0] ssd5;
    logic [6:0] ssd4;
    logic [6:0] ssd3;
    logic [6:0] ssd2;
    logic [6:0] ssd1;
    logic [6:0] ssd0;

    int          err_mismatch;
    int          err_other;
    logic [31:0] seed;
    int          sa;
    int          sb;
    logic [2:0]  col;     // model puck column, row and direction
    logic [2:0]  row;
    logic [1:0]  dir;
    logic        server_a;
    logic        a_scored;

    hockey_top i_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (exp === act) else begin
            $display("mismatch %s expected %0h actual %0h", name, exp, act);
            err_mismatch++;
        end
    endtask

    task automatic check_idle();
        check("idle led_a", 8'(1), 8'(led_a));
        check("idle led_b", 8'(1), 8'(led_b));
        check("idle led_x", 8'(0), 8'(led_x));
        check("idle ssd7", 8'(SSD_BLANK), 8'(ssd7));
        check("idle ssd6", 8'(SSD_BLANK), 8'(ssd6));
        check("idle ssd5", 8'(SSD_BLANK), 8'(ssd5));
        check("idle ssd4", 8'(SSD_BLANK), 8'(ssd4));
        check("idle ssd3", 8'(SSD_BLANK), 8'(ssd3));
        check("idle ssd2", 8'(SSD_BLANK), 8'(ssd2));
        check("idle ssd1", 8'(SSD_BLANK), 8'(ssd1));
        check("idle ssd0", 8'(SSD_BLANK), 8'(ssd0));
    endtask

    // hold the row at a wall and reverse the direction
    task automatic move_row();
        if (dir == 2'd1) begin
            if (row == Y_MAX) dir = 2'd2;
            else row = row + 3'd1;
        end else if (dir == 2'd2) begin
            if (row == 3'd0) dir = 2'd1;
            else row = row - 3'd1;
        end
    endtask

    task automatic wait_leds(input string what, input logic a, input logic b,
                             input logic [4:0] x);
        int n;
        n = 0;
        @(negedge clk);
        while (!(led_a == a && led_b == b && led_x == x) && n < 30) begin
            @(negedge clk);
            n++;
        end
        if (n >= 30) begin
            $display("no %s display appeared in time", what);
            err_other++;
        end
    endtask

    task automatic play_rally(input logic a_serves, output logic a_wins);
        logic        to_b;
        logic        done;
        logic [31:0] r;
        int          hits;
        int          choice;
        wait_leds("serve", a_serves, !a_serves, 5'h00);
        r = lcg();
        @(posedge clk);
        if (a_serves) begin
            btn_a <= 1'b1;
            y_a   <= 3'(r[7:0] % 8'd5);
            dir_a <= r[9:8];
        end else begin
            btn_b <= 1'b1;
            y_b   <= 3'(r[7:0] % 8'd5);
            dir_b <= r[9:8];
        end
        row = 3'(r[7:0] % 8'd5);
        dir = r[9:8];
        @(posedge clk);   // load edge
        btn_a <= 1'b0;
        btn_b <= 1'b0;
        col    = a_serves ? 3'd0 : X_MAX;
        to_b   = a_serves;
        hits   = 0;
        done   = 1'b0;
        choice = 0;
        while (!done) begin
            for (int k = 1; k <= int'(X_MAX); k++) begin
                @(posedge clk);
                col = to_b ? col + 3'd1 : col - 3'd1;
                move_row();
                if (k == int'(X_MAX)) begin
                    r = lcg();
                    choice = (hits >= 3) ? 1 + int'(r[4]) : int'(r[7:0] % 8'd3);
                    if (choice != 2) begin
                        if (to_b) begin
                            btn_b <= 1'b1;
                            y_b   <= (choice == 0) ? row : 3'((row + 3'd1) % 3'd5);
                            dir_b <= r[11:10];
                        end else begin
                            btn_a <= 1'b1;
                            y_a   <= (choice == 0) ? row : 3'((row + 3'd1) % 3'd5);
                            dir_a <= r[11:10];
                        end
                    end
                end
                @(negedge clk);
                check("travel led_x", 8'(5'b00001 << col), 8'(led_x));
            end
            @(posedge clk);   // first response cycle ends here
            btn_a <= 1'b0;
            btn_b <= 1'b0;
            if (choice == 0) begin
                dir  = r[11:10];
                to_b = !to_b;
                hits++;
            end else begin
                done   = 1'b1;
                a_wins = to_b;   // sender scores on a miss
            end
        end
        wait_leds("goal", 1'b0, 1'b0, 5'h1f);
        if (a_wins) sa++;
        else sb++;
        check("goal ssd4", 8'(SSD_DIGIT[sa]), 8'(ssd4));
        check("goal ssd0", 8'(SSD_DIGIT[sb]), 8'(ssd0));
        check("goal led_x", 8'h1f, 8'(led_x));
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the game finished");
        $display("Something failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        btn_a = 1'b0;
        btn_b = 1'b0;
        dir_a = 2'd0;
        dir_b = 2'd0;
        y_a = 3'd0;
        y_b = 3'd0;
        seed = 32'hef4f_f5f7;
        err_mismatch = 0;
        err_other = 0;
        sa = 0;
        sb = 0;
        repeat (5) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        btn_a <= 1'b1;   // A serves first
        @(posedge clk);
        btn_a <= 1'b0;
        wait_leds("intro", 1'b0, 1'b0, 5'h1f);
        check("intro ssd4", 8'(SSD_DIGIT[0]), 8'(ssd4));
        check("intro ssd0", 8'(SSD_DIGIT[0]), 8'(ssd0));
        check("intro ssd7", 8'(SSD_DASH), 8'(ssd7));
        server_a = 1'b1;
        while (sa < int'(WIN_SCORE) && sb < int'(WIN_SCORE)) begin
            play_rally(server_a, a_scored);
            server_a = !a_scored;   // conceding player serves
        end
        wait_leds("game over", 1'b0, 1'b0, LED_GAMEOVER);
        repeat (10) begin
            @(negedge clk);
            check("over led_x", 8'(LED_GAMEOVER), 8'(led_x));
            check("over ssd4", 8'(SSD_DIGIT[sa]), 8'(ssd4));
            check("over ssd0", 8'(SSD_DIGIT[sb]), 8'(ssd0));
        end
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_idle();
        $display("errors: mismatch %0d, other %0d", err_mismatch, err_other);
        if (err_mismatch == 0 && err_other == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hockey_pkg.sv
puck_if.sv
puck_tracker.sv
rally_fsm.sv
court_display.sv
hockey_top.sv
tb_hockey_assert.sv
tb_hockey.sv

/* run_sim.sh */
#!/bin/sh
# build and run the air hockey testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hockey -f flist.f -o sim_hockey \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_hockey > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
